/* hdl/chitchat_params.svh */
/*
 * Frame layout and protocol constants of the chitchat link.
 * The frame index logic is four bits wide, so CC_FRAME_WORDS must stay at 16 or below.
 * The CRC is CRC-16-CCITT and shifts 16 bits per word, MSB first.
 */

`ifndef CHITCHAT_PARAMS_SVH
`define CHITCHAT_PARAMS_SVH

// --------------------------------------------------
// Frame layout
// --------------------------------------------------
`define CC_FRAME_WORDS   11
// Comma, sent with k high as word 0
`define CC_COMMA         16'h3CBC

// --------------------------------------------------
// Protocol identity
// --------------------------------------------------
`define CC_PROTOCOL_VER  4'h1
`define CC_GATEWARE_TYPE 3'h2

// --------------------------------------------------
// CRC and loss of signal
// --------------------------------------------------
`define CC_CRC_POLY      16'h1021
`define CC_CRC_INIT      16'hFFFF
// Words without a comma before LOS is flagged
`define CC_LOS_LIMIT     16'd64

`endif

/* hdl/chitchat_pkg.sv */
/*
 * Types shared by the chitchat transmitter, receiver and top level.
 * Widths are fixed by the frame layout and must not change on their own.
 */

`default_nettype none

package chitchat_pkg;

   // --------------------------------------------------
   // Link and payload words
   // --------------------------------------------------
   // One 16-bit word on the transceiver data path
   typedef logic [15:0] cc_word_t;

   // User payload, sent as two link words
   typedef logic [31:0] cc_data_t;

   // Frame counters, fault counter and latency
   typedef logic [15:0] cc_count_t;

   // --------------------------------------------------
   // Header fields
   // --------------------------------------------------
   typedef logic [3:0]  cc_ver_t;
   typedef logic [2:0]  cc_type_t;
   typedef logic [2:0]  cc_loc_t;
   typedef logic [31:0] cc_rev_t;

   // Fault flags
   //   bit 0  CRC error
   //   bit 1  protocol version mismatch
   //   bit 2  malformed frame, k seen inside the body
   typedef logic [2:0]  cc_fault_t;

   // --------------------------------------------------
   // Receiver FSM
   // --------------------------------------------------
   typedef enum logic [0:0] {
      st_hunt,
      st_body
   } cc_rx_state_t;

endpackage

`default_nettype wire

/* hdl/chitchat_crc16.sv */
/*
 * Word-wide CRC-16 accumulator.
 * Clear wins over enable. The folded value is readable in the cycle
 * after the last enable.
 */

`default_nettype none

`include "chitchat_params.svh"

module chitchat_crc16 (
   input  wire                    gtx_tx_clk,
   input  wire                    rst_n,
   input  wire logic              clear,
   input  wire logic              enable,
   input  wire chitchat_pkg::cc_word_t data,
   output chitchat_pkg::cc_word_t crc
);

   import chitchat_pkg::*;

   // Fold one 16-bit word, MSB first
   function automatic cc_word_t crc_fold(input cc_word_t c_in, input cc_word_t d);
      cc_word_t c;
      logic     fb;
      c = c_in;
      for (int i = 15; i >= 0; i--) begin
         fb = c[15] ^ d[i];
         c  = {c[14:0], 1'b0} ^ (fb ? `CC_CRC_POLY : 16'h0000);
      end
      return c;
   endfunction

   always_ff @(posedge gtx_tx_clk) begin
      if (!rst_n) begin
         crc <= `CC_CRC_INIT;
      end else if (clear) begin
         crc <= `CC_CRC_INIT;
      end else if (enable) begin
         crc <= crc_fold(crc, data);
      end
   end

endmodule

`default_nettype wire

/* hdl/chitchat_tx.sv */
/*
 * Chitchat frame sequencer.
 * Frames follow each other with no gap while tx_transmit_en is high.
 * Data is sampled only when word 0 goes out; the caller keeps it stable before then.
 * A frame in progress always completes after tx_transmit_en drops.
 */

`default_nettype none

`include "chitchat_params.svh"

module chitchat_tx #(
   parameter chitchat_pkg::cc_rev_t REV_ID = 32'h0000_0000
) (
   input  wire                      gtx_tx_clk,
   input  wire                      rst_n,

   input  wire logic                tx_transmit_en,
   input  wire chitchat_pkg::cc_loc_t   tx_location,
   input  wire chitchat_pkg::cc_data_t  tx_data0,
   input  wire chitchat_pkg::cc_data_t  tx_data1,
   input  wire chitchat_pkg::cc_count_t tx_loopback_frame_counter,

   output logic                     tx_send,
   output chitchat_pkg::cc_count_t  local_frame_counter,

   output chitchat_pkg::cc_word_t   gtx_d,
   output logic                     gtx_k
);

   import chitchat_pkg::*;

   localparam logic [3:0] last_idx = 4'(`CC_FRAME_WORDS - 1);

   logic [3:0] idx;
   logic       start;
   cc_word_t   next_d;
   logic       next_k;
   cc_word_t   crc;
   cc_data_t   data0_s;
   cc_data_t   data1_s;

   assign start = (idx == 4'd0) && tx_transmit_en;

   // --------------------------------------------------
   // Word multiplexer
   // --------------------------------------------------
   always_comb begin
      next_d = '0;
      next_k = 1'b0;
      case (idx)
         4'd0: begin
            if (tx_transmit_en) begin
               next_d = `CC_COMMA;
               next_k = 1'b1;
            end
         end
         4'd1:    next_d = {`CC_PROTOCOL_VER, `CC_GATEWARE_TYPE, tx_location, 6'b0};
         4'd2:    next_d = REV_ID[31:16];
         4'd3:    next_d = REV_ID[15:0];
         4'd4:    next_d = data0_s[31:16];
         4'd5:    next_d = data0_s[15:0];
         4'd6:    next_d = data1_s[31:16];
         4'd7:    next_d = data1_s[15:0];
         // Counter already holds the number of this frame
         4'd8:    next_d = local_frame_counter;
         4'd9:    next_d = tx_loopback_frame_counter;
         4'd10:   next_d = crc;
         default: next_d = '0;
      endcase
   end

   // --------------------------------------------------
   // Sequencer and output registers
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (!rst_n) begin
         idx                 <= '0;
         gtx_d               <= '0;
         gtx_k               <= 1'b0;
         tx_send             <= 1'b0;
         local_frame_counter <= '0;
      end else begin
         gtx_d   <= next_d;
         gtx_k   <= next_k;
         tx_send <= start;
         if (start) begin
            local_frame_counter <= local_frame_counter + 16'd1;
            idx                 <= 4'd1;
         end else if (idx == last_idx) begin
            idx <= '0;
         end else if (idx != 4'd0) begin
            idx <= idx + 4'd1;
         end
      end
   end

   // Payload snapshot for the frame that starts now
   always_ff @(posedge gtx_tx_clk) begin
      if (start) begin
         data0_s <= tx_data0;
         data1_s <= tx_data1;
      end
   end

   // CRC covers words 1 to 9
   chitchat_crc16 u_crc (
      .gtx_tx_clk (gtx_tx_clk),
      .rst_n      (rst_n),
      .clear      (idx == 4'd0),
      .enable     ((idx != 4'd0) && (idx != last_idx)),
      .data       (next_d),
      .crc        (crc)
   );

   idx_in_range: assert property (@(posedge gtx_tx_clk) disable iff (!rst_n)
      idx <= last_idx);

endmodule

`default_nettype wire

/* hdl/chitchat_rx.sv */
/*
 * Chitchat receiver.
 * Locks on a comma with k high and takes the next ten words as the frame body.
 * A k or comma inside the body does not resync; the frame is dropped at its end.
 * ccrx_los is high out of reset and clears only on a clean frame.
 */

`default_nettype none

`include "chitchat_params.svh"

module chitchat_rx (
   input  wire                       gtx_tx_clk,
   input  wire                       rst_n,

   input  wire chitchat_pkg::cc_word_t   gtx_d,
   input  wire logic                 gtx_k,

   output logic                      rx_valid,
   output logic                      ccrx_frame_drop,
   output chitchat_pkg::cc_data_t    rx_data0,
   output chitchat_pkg::cc_data_t    rx_data1,
   output chitchat_pkg::cc_count_t   rx_frame_counter,
   output chitchat_pkg::cc_count_t   rx_loopback_frame_counter,
   output chitchat_pkg::cc_ver_t     rx_protocol_ver,
   output chitchat_pkg::cc_type_t    rx_gateware_type,
   output chitchat_pkg::cc_loc_t     rx_location,
   output chitchat_pkg::cc_rev_t     rx_rev_id,

   output chitchat_pkg::cc_fault_t   ccrx_fault,
   output chitchat_pkg::cc_count_t   ccrx_fault_cnt,
   output logic                      ccrx_los
);

   import chitchat_pkg::*;

   localparam logic [3:0] last_idx = 4'(`CC_FRAME_WORDS - 1);

   cc_rx_state_t state;
   logic [3:0]   widx;
   logic         bad_k;
   logic         is_comma;
   logic         frame_end;
   logic         frame_ok;
   cc_fault_t    fault_now;
   cc_word_t     crc;
   cc_count_t    los_cnt;

   // Shadow registers, filled while the body streams in
   cc_ver_t      sh_ver;
   cc_type_t     sh_type;
   cc_loc_t      sh_loc;
   cc_rev_t      sh_rev;
   cc_data_t     sh_data0;
   cc_data_t     sh_data1;
   cc_count_t    sh_fc;
   cc_count_t    sh_lbfc;

   assign is_comma  = gtx_k && (gtx_d == `CC_COMMA);
   assign frame_end = (state == st_body) && (widx == last_idx);

   // CRC word is on the line at the frame end
   assign fault_now = {bad_k | gtx_k, sh_ver != `CC_PROTOCOL_VER, gtx_d != crc};
   assign frame_ok  = (fault_now == '0);

   // --------------------------------------------------
   // Comma hunt and body FSM
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (!rst_n) begin
         state <= st_hunt;
         widx  <= '0;
         bad_k <= 1'b0;
      end else begin
         case (state)
            st_hunt: begin
               if (is_comma) begin
                  state <= st_body;
                  widx  <= 4'd1;
                  bad_k <= 1'b0;
               end
            end
            st_body: begin
               bad_k <= bad_k | gtx_k;
               if (widx == last_idx) begin
                  state <= st_hunt;
               end else begin
                  widx <= widx + 4'd1;
               end
            end
            default: state <= st_hunt;
         endcase
      end
   end

   always_ff @(posedge gtx_tx_clk) begin
      if (state == st_body) begin
         case (widx)
            4'd1:    {sh_ver, sh_type, sh_loc} <= gtx_d[15:6];
            4'd2:    sh_rev[31:16]   <= gtx_d;
            4'd3:    sh_rev[15:0]    <= gtx_d;
            4'd4:    sh_data0[31:16] <= gtx_d;
            4'd5:    sh_data0[15:0]  <= gtx_d;
            4'd6:    sh_data1[31:16] <= gtx_d;
            4'd7:    sh_data1[15:0]  <= gtx_d;
            4'd8:    sh_fc           <= gtx_d;
            4'd9:    sh_lbfc         <= gtx_d;
            default: ;
         endcase
      end
   end

   chitchat_crc16 u_crc (
      .gtx_tx_clk (gtx_tx_clk),
      .rst_n      (rst_n),
      .clear      (state == st_hunt),
      .enable     ((state == st_body) && (widx != last_idx)),
      .data       (gtx_d),
      .crc        (crc)
   );

   // --------------------------------------------------
   // Frame verdict and fault counting
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (!rst_n) begin
         rx_valid                  <= 1'b0;
         ccrx_frame_drop           <= 1'b0;
         ccrx_fault                <= '0;
         ccrx_fault_cnt            <= '0;
         rx_frame_counter          <= '0;
         rx_loopback_frame_counter <= '0;
      end else begin
         rx_valid        <= frame_end && frame_ok;
         ccrx_frame_drop <= frame_end && !frame_ok;
         if (frame_end && frame_ok) begin
            ccrx_fault                <= '0;
            rx_frame_counter          <= sh_fc;
            rx_loopback_frame_counter <= sh_lbfc;
         end else if (frame_end) begin
            ccrx_fault <= fault_now;
            // Saturates at all ones
            if (ccrx_fault_cnt != 16'hFFFF) begin
               ccrx_fault_cnt <= ccrx_fault_cnt + 16'd1;
            end
         end
      end
   end

   always_ff @(posedge gtx_tx_clk) begin
      if (frame_end && frame_ok) begin
         rx_data0         <= sh_data0;
         rx_data1         <= sh_data1;
         rx_protocol_ver  <= sh_ver;
         rx_gateware_type <= sh_type;
         rx_location      <= sh_loc;
         rx_rev_id        <= sh_rev;
      end
   end

   // --------------------------------------------------
   // Loss of signal
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (!rst_n) begin
         los_cnt  <= '0;
         ccrx_los <= 1'b1;
      end else begin
         if (is_comma) begin
            los_cnt <= '0;
         end else if (los_cnt != `CC_LOS_LIMIT) begin
            los_cnt <= los_cnt + 16'd1;
         end
         if (frame_end && frame_ok) begin
            ccrx_los <= 1'b0;
         end else if (los_cnt == `CC_LOS_LIMIT) begin
            ccrx_los <= 1'b1;
         end
      end
   end

   valid_drop_excl: assert property (@(posedge gtx_tx_clk) disable iff (!rst_n)
      !(rx_valid && ccrx_frame_drop));

endmodule

`default_nettype wire

/* hdl/chitchat_txrx_wrap.sv */
/*
 * Chitchat top level with all logic on gtx_tx_clk.
 * tx_data0/tx_data1 are latched on tx_valid and sent with the next frame;
 * a second tx_valid before tx_send overwrites the first pair.
 * txrx_latency is in frames and valid one cycle after rx_valid.
 */

`default_nettype none

module chitchat_txrx_wrap #(
   parameter chitchat_pkg::cc_rev_t REV_ID = 32'h0000_0000
) (
   input  wire                       gtx_tx_clk,
   input  wire                       rst_n,

   // User transmit side
   input  wire logic                 tx_transmit_en,
   input  wire logic                 tx_valid,
   input  wire chitchat_pkg::cc_loc_t    tx_location,
   input  wire chitchat_pkg::cc_data_t   tx_data0,
   input  wire chitchat_pkg::cc_data_t   tx_data1,

   // User receive side
   output logic                      rx_valid,
   output logic                      ccrx_frame_drop,
   output chitchat_pkg::cc_data_t    rx_data0,
   output chitchat_pkg::cc_data_t    rx_data1,

   // Status
   output chitchat_pkg::cc_count_t   rx_frame_counter,
   output chitchat_pkg::cc_ver_t     rx_protocol_ver,
   output chitchat_pkg::cc_type_t    rx_gateware_type,
   output chitchat_pkg::cc_loc_t     rx_location,
   output chitchat_pkg::cc_rev_t     rx_rev_id,
   output chitchat_pkg::cc_fault_t   ccrx_fault,
   output chitchat_pkg::cc_count_t   ccrx_fault_cnt,
   output logic                      ccrx_los,
   output chitchat_pkg::cc_count_t   txrx_latency,

   // Transceiver data path
   output chitchat_pkg::cc_word_t    gtx_tx_d,
   output logic                      gtx_tx_k,
   input  wire chitchat_pkg::cc_word_t   gtx_rx_d,
   input  wire logic                 gtx_rx_k
);

   import chitchat_pkg::*;

   cc_data_t  tx_data0_r;
   cc_data_t  tx_data1_r;
   cc_loc_t   tx_location_r;
   logic      tx_transmit_en_r;
   cc_count_t local_frame_counter;
   cc_count_t rx_lb_frame_counter;

   // --------------------------------------------------
   // Input latch and quasi-static registers
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (tx_valid) begin
         tx_data0_r <= tx_data0;
         tx_data1_r <= tx_data1;
      end
      tx_location_r <= tx_location;
   end

   always_ff @(posedge gtx_tx_clk) begin
      if (!rst_n) begin
         tx_transmit_en_r <= 1'b0;
      end else begin
         tx_transmit_en_r <= tx_transmit_en;
      end
   end

   chitchat_tx #(
      .REV_ID (REV_ID)
   ) u_tx (
      .gtx_tx_clk                (gtx_tx_clk),
      .rst_n                     (rst_n),
      .tx_transmit_en            (tx_transmit_en_r),
      .tx_location               (tx_location_r),
      .tx_data0                  (tx_data0_r),
      .tx_data1                  (tx_data1_r),
      .tx_loopback_frame_counter (rx_frame_counter),
      .tx_send                   (),
      .local_frame_counter       (local_frame_counter),
      .gtx_d                     (gtx_tx_d),
      .gtx_k                     (gtx_tx_k)
   );

   chitchat_rx u_rx (
      .gtx_tx_clk                (gtx_tx_clk),
      .rst_n                     (rst_n),
      .gtx_d                     (gtx_rx_d),
      .gtx_k                     (gtx_rx_k),
      .rx_valid                  (rx_valid),
      .ccrx_frame_drop           (ccrx_frame_drop),
      .rx_data0                  (rx_data0),
      .rx_data1                  (rx_data1),
      .rx_frame_counter          (rx_frame_counter),
      .rx_loopback_frame_counter (rx_lb_frame_counter),
      .rx_protocol_ver           (rx_protocol_ver),
      .rx_gateware_type          (rx_gateware_type),
      .rx_location               (rx_location),
      .rx_rev_id                 (rx_rev_id),
      .ccrx_fault                (ccrx_fault),
      .ccrx_fault_cnt            (ccrx_fault_cnt),
      .ccrx_los                  (ccrx_los)
   );

   // --------------------------------------------------
   // Loopback latency in frames
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (!rst_n) begin
         txrx_latency <= '0;
      end else if (rx_valid) begin
         txrx_latency <= local_frame_counter - rx_lb_frame_counter;
      end
   end

endmodule

`default_nettype wire

/* testbench/chitchat_tb.sv */
/*
 * Loopback testbench for chitchat_txrx_wrap with everything on gtx_tx_clk.
 * gtx_rx_d is gtx_tx_d XOR an error mask; gtx_rx_k can be forced high.
 * Every sent frame must end in either rx_valid or ccrx_frame_drop.
 */

`default_nettype none

`include "chitchat_params.svh"

module chitchat_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] rev_id = 32'h0000_1234;
   localparam logic [2:0]  tb_loc = 3'h5;
   localparam int timeout_cycles =
      (40 * `CC_FRAME_WORDS + int'(`CC_LOS_LIMIT)) * 2;

   logic        gtx_tx_clk;
   logic        rst_n;
   logic        tx_transmit_en;
   logic        tx_valid;
   logic [2:0]  tx_location;
   logic [31:0] tx_data0;
   logic [31:0] tx_data1;
   logic        rx_valid;
   logic        ccrx_frame_drop;
   logic [31:0] rx_data0;
   logic [31:0] rx_data1;
   logic [15:0] rx_frame_counter;
   logic [3:0]  rx_protocol_ver;
   logic [2:0]  rx_gateware_type;
   logic [2:0]  rx_location;
   logic [31:0] rx_rev_id;
   logic [2:0]  ccrx_fault;
   logic [15:0] ccrx_fault_cnt;
   logic        ccrx_los;
   logic [15:0] txrx_latency;
   logic [15:0] gtx_tx_d;
   logic        gtx_tx_k;
   logic [15:0] gtx_rx_d;
   logic        gtx_rx_k;

   // Error injection
   logic [15:0] d_mask;
   logic        k_force;

   integer      seed;
   logic [31:0] cur0;
   logic [31:0] cur1;
   logic [15:0] sent_cnt;
   logic [79:0] exp_q[$];
   logic [2:0]  exp_fault;
   int          good_cnt;
   int          cycle_cnt;

   assign gtx_rx_d = gtx_tx_d ^ d_mask;
   assign gtx_rx_k = gtx_tx_k | k_force;

   chitchat_txrx_wrap #(
      .REV_ID (rev_id)
   ) u_dut (
      .gtx_tx_clk       (gtx_tx_clk),
      .rst_n            (rst_n),
      .tx_transmit_en   (tx_transmit_en),
      .tx_valid         (tx_valid),
      .tx_location      (tx_location),
      .tx_data0         (tx_data0),
      .tx_data1         (tx_data1),
      .rx_valid         (rx_valid),
      .ccrx_frame_drop  (ccrx_frame_drop),
      .rx_data0         (rx_data0),
      .rx_data1         (rx_data1),
      .rx_frame_counter (rx_frame_counter),
      .rx_protocol_ver  (rx_protocol_ver),
      .rx_gateware_type (rx_gateware_type),
      .rx_location      (rx_location),
      .rx_rev_id        (rx_rev_id),
      .ccrx_fault       (ccrx_fault),
      .ccrx_fault_cnt   (ccrx_fault_cnt),
      .ccrx_los         (ccrx_los),
      .txrx_latency     (txrx_latency),
      .gtx_tx_d         (gtx_tx_d),
      .gtx_tx_k         (gtx_tx_k),
      .gtx_rx_d         (gtx_rx_d),
      .gtx_rx_k         (gtx_rx_k)
   );

   always #5 gtx_tx_clk = ~gtx_tx_clk;

   // --------------------------------------------------
   // Reference model and reporting
   // --------------------------------------------------
   // Bit-serial CRC-16-CCITT over words 1 to 9 with word 1 first
   function automatic logic [15:0] ref_crc(input logic [143:0] body);
      logic [15:0] c;
      logic        fb;
      c = `CC_CRC_INIT;
      for (int i = 143; i >= 0; i--) begin
         fb = c[15] ^ body[i];
         c  = {c[14:0], 1'b0};
         if (fb) begin
            c = c ^ `CC_CRC_POLY;
         end
      end
      return c;
   endfunction

   task automatic abort_run(input string why);
      $display("Errors found");
      $fatal(1, "%s", why);
   endtask

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      if (expected !== actual) begin
         $display("Fail %s expected %0h actual %0h", name, expected, actual);
         abort_run("a checked value was wrong");
      end
   endtask

   // Returns at the edge that ends the cycle with word 0 on the line
   task automatic wait_send();
      do begin
         @(posedge gtx_tx_clk);
      end while (tx_send_seen() == 1'b0);
   endtask

   function automatic logic tx_send_seen();
      return gtx_tx_k === 1'b1 && gtx_tx_d === `CC_COMMA;
   endfunction

   task automatic wait_good(input int n);
      int target;
      target = good_cnt + n;
      while (good_cnt < target) begin
         @(posedge gtx_tx_clk);
      end
   endtask

   // --------------------------------------------------
   // Data refresh one cycle after each frame start
   // --------------------------------------------------
   always @(posedge gtx_tx_clk) begin
      if (rst_n) begin
         tx_valid <= 1'b0;
         if (tx_send_seen()) begin
            sent_cnt = sent_cnt + 16'd1;
            exp_q.push_back({sent_cnt, cur0, cur1});
            cur0 = $random(seed);
            cur1 = $random(seed);
            tx_data0 <= cur0;
            tx_data1 <= cur1;
            tx_valid <= 1'b1;
         end
      end
   end

   // --------------------------------------------------
   // Transmit stream monitor
   // --------------------------------------------------
   int          mon_pos;
   logic [15:0] mon_w [1:10];
   logic [143:0] body;

   always @(posedge gtx_tx_clk) begin
      if (rst_n) begin
         if (mon_pos == 0) begin
            if (gtx_tx_k) begin
               check("tx comma", 64'(`CC_COMMA), 64'(gtx_tx_d));
               mon_pos = 1;
            end else begin
               check("tx idle word", 64'd0, 64'(gtx_tx_d));
            end
         end else begin
            check("tx body k", 64'd0, 64'(gtx_tx_k));
            mon_w[mon_pos] = gtx_tx_d;
            if (mon_pos == 10) begin
               body = '0;
               for (int i = 1; i <= 9; i++) begin
                  body = {body[127:0], mon_w[i]};
               end
               check("tx header word",
                     64'({`CC_PROTOCOL_VER, `CC_GATEWARE_TYPE, tb_loc, 6'b0}),
                     64'(mon_w[1]));
               check("tx rev id", 64'(rev_id), 64'({mon_w[2], mon_w[3]}));
               check("tx crc", 64'(ref_crc(body)), 64'(mon_w[10]));
               mon_pos = 0;
            end else begin
               mon_pos = mon_pos + 1;
            end
         end
      end
   end

   // --------------------------------------------------
   // Receive checker
   // --------------------------------------------------
   logic [79:0] entry;
   logic [15:0] fault_model;
   logic [15:0] prev_fc;
   logic [15:0] drops_since;
   logic        lat_check;

   always @(posedge gtx_tx_clk) begin
      if (rst_n) begin
         if (lat_check) begin
            // Two frames between send and echo in direct loopback
            check("latency", 64'd2, 64'(txrx_latency));
            lat_check <= 1'b0;
         end
         if (rx_valid) begin
            if (exp_q.size() == 0) begin
               abort_run("rx_valid with no frame outstanding");
            end
            if (exp_fault != 3'b000) begin
               abort_run("a corrupted frame was accepted");
            end
            entry = exp_q.pop_front();
            check("rx data0", 64'(entry[63:32]), 64'(rx_data0));
            check("rx data1", 64'(entry[31:0]), 64'(rx_data1));
            check("rx frame counter", 64'(entry[79:64]), 64'(rx_frame_counter));
            check("frame counter step", 64'(prev_fc + 16'd1 + drops_since),
                  64'(rx_frame_counter));
            check("rx rev id", 64'(rev_id), 64'(rx_rev_id));
            check("rx location", 64'(tb_loc), 64'(rx_location));
            check("rx version", 64'(`CC_PROTOCOL_VER), 64'(rx_protocol_ver));
            check("rx gateware type", 64'(`CC_GATEWARE_TYPE), 64'(rx_gateware_type));
            check("fault after good frame", 64'd0, 64'(ccrx_fault));
            check("fault count", 64'(fault_model), 64'(ccrx_fault_cnt));
            check("rx_valid with drop", 64'd0, 64'(ccrx_frame_drop));
            prev_fc     = entry[79:64];
            drops_since = 16'd0;
            if (good_cnt == 1) begin
               lat_check <= 1'b1;
            end
            good_cnt <= good_cnt + 1;
         end
         if (ccrx_frame_drop) begin
            if (exp_fault == 3'b000) begin
               abort_run("frame dropped without injected error");
            end
            // The dropped frame's data is discarded
            entry       = exp_q.pop_front();
            fault_model = fault_model + 16'd1;
            drops_since = drops_since + 16'd1;
            check("drop fault flags", 64'(exp_fault), 64'(ccrx_fault));
            check("drop fault count", 64'(fault_model), 64'(ccrx_fault_cnt));
            exp_fault <= 3'b000;
         end
      end
   end

   // --------------------------------------------------
   // Timeout
   // --------------------------------------------------
   always @(posedge gtx_tx_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > timeout_cycles) begin
         abort_run("simulation ran past its cycle limit");
      end
   end

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      gtx_tx_clk     = 1'b0;
      rst_n          = 1'b0;
      tx_transmit_en = 1'b0;
      tx_valid       = 1'b0;
      tx_location    = tb_loc;
      tx_data0       = '0;
      tx_data1       = '0;
      d_mask         = '0;
      k_force        = 1'b0;
      seed           = 32'h10c7;
      sent_cnt       = '0;
      exp_fault      = '0;
      good_cnt       = 0;
      cycle_cnt      = 0;
      mon_pos        = 0;
      fault_model    = '0;
      prev_fc        = '0;
      drops_since    = '0;
      lat_check      = 1'b0;

      repeat (5) @(posedge gtx_tx_clk);
      cur0 = $random(seed);
      cur1 = $random(seed);
      rst_n          <= 1'b1;
      tx_data0       <= cur0;
      tx_data1       <= cur1;
      tx_valid       <= 1'b1;
      tx_transmit_en <= 1'b1;

      // Round trip, counters and latency
      wait_good(4);

      // Single bit flip in word 5
      wait_send();
      repeat (4) @(posedge gtx_tx_clk);
      exp_fault = 3'b001;
      d_mask <= 16'h0100;
      @(posedge gtx_tx_clk);
      d_mask <= 16'h0000;
      wait_good(2);

      // k forced high on word 3
      wait_send();
      repeat (2) @(posedge gtx_tx_clk);
      exp_fault = 3'b100;
      k_force <= 1'b1;
      @(posedge gtx_tx_clk);
      k_force <= 1'b0;
      wait_good(2);

      // Loss of signal
      check("los while linked", 64'd0, 64'(ccrx_los));
      tx_transmit_en <= 1'b0;
      do begin
         @(posedge gtx_tx_clk);
      end while (ccrx_los !== 1'b1);
      tx_transmit_en <= 1'b1;
      do begin
         @(posedge gtx_tx_clk);
      end while (rx_valid !== 1'b1);
      check("los after good frame", 64'd0, 64'(ccrx_los));
      wait_good(2);

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/chitchat_pkg.sv
hdl/chitchat_crc16.sv
hdl/chitchat_tx.sv
hdl/chitchat_rx.sv
hdl/chitchat_txrx_wrap.sv
testbench/chitchat_tb.sv

/* Makefile */
# Verilator build and run for the chitchat link testbench

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= chitchat_tb
RTL_TOP   ?= chitchat_txrx_wrap
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
